//--- Makefile
# Verilator build and run of the decode/execute testbench

TOP := tb_decode_execute
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "test run reported a failure"; \
		exit 1; \
	fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dx_branch.sv
// branch resolution in decode, gives taken, target, link/next pc, mispredict target and alignment
`default_nettype none

`include "dx_defines.svh"

module dx_branch (
   input  wire                                   pipeline_flush_i,
   input  wire dx_pkg::operand_t                   decode_pc_i,
   input  wire dx_pkg::op_class_e                  decode_op_i,
   input  wire [`DX_IMM16_WIDTH-1:0]             decode_imm16_i,
   input  wire [`DX_IMMJBR_UPPER_WIDTH-1:0]      decode_immjbr_upper_i,
   input  wire                                   predicted_flag_i,
   input  wire dx_pkg::operand_t                   decode_rfb_i,
   input  wire dx_pkg::operand_t                   execute_rfb_i,
   input  wire                                   jr_ready_i,
   input  wire                                   execute_bubble_i,
   input  wire dx_pkg::op_class_e                  execute_op_i,
   output logic                                  decode_branch_o,
   output dx_pkg::operand_t                        decode_branch_target_o,
   output dx_pkg::operand_t                        next_pc_o,
   output dx_pkg::operand_t                        mispredict_target_o,
   output logic                                  ibus_align_o
);

   import dx_pkg::*;

   localparam int OFFS_WIDTH = `DX_IMMJBR_UPPER_WIDTH + `DX_IMM16_WIDTH;
   localparam int SEXT_WIDTH = `DX_OPERAND_WIDTH - OFFS_WIDTH - 2;

   logic [OFFS_WIDTH-1:0] word_offset;
   operand_t              byte_offset;
   operand_t              imm_target;
   operand_t              reg_target;
   logic                  imm_taken;
   logic                  reg_taken;
   logic                  bf_mispredict_imm;

   // word offset of the jump, sign extended then scaled to bytes
   assign word_offset = {decode_immjbr_upper_i, decode_imm16_i};
   assign byte_offset = {{SEXT_WIDTH{word_offset[OFFS_WIDTH-1]}}, word_offset, 2'b00};
   assign imm_target  = decode_pc_i + byte_offset;

   // conditional branches follow the predicted flag
   always_comb begin
      case (decode_op_i)
         OP_JUMP,
         OP_JAL:  imm_taken = 1'b1;
         OP_BF:   imm_taken = predicted_flag_i;
         OP_BNF:  imm_taken = ~predicted_flag_i;
         default: imm_taken = 1'b0;
      endcase
   end

   assign reg_taken = (decode_op_i == OP_JR) & jr_ready_i;

   // after a bubble the producer of rfb has moved on, so read the
   // execute-side operand, same if a jr already sits in execute
   assign reg_target = (execute_bubble_i || (execute_op_i == OP_JR)) ?
                       execute_rfb_i : decode_rfb_i;

   assign decode_branch_o        = (imm_taken | reg_taken) & ~pipeline_flush_i;
   assign decode_branch_target_o = imm_taken ? imm_target : reg_target;

   // fall-through and link address
   assign next_pc_o = (`DX_DELAY_SLOT != 0) ? decode_pc_i + operand_t'(8) :
                                             decode_pc_i + operand_t'(4);

   // predicted not taken, so a mispredict goes to the branch target
   assign bf_mispredict_imm = ((decode_op_i == OP_BF) & ~predicted_flag_i) |
                              ((decode_op_i == OP_BNF) & predicted_flag_i);

   assign mispredict_target_o = bf_mispredict_imm ? imm_target : next_pc_o;

   // instructions are word aligned
   assign ibus_align_o = decode_branch_o & (|decode_branch_target_o[1:0]);

endmodule

`default_nettype wire

//--- dx_decode_execute.sv
// decode to execute boundary top, hazard detection, branch resolution and the execute register
`default_nettype none

`include "dx_defines.svh"

module dx_decode_execute (
   input  wire                              clk,
   input  wire                              rst,
   input  wire                              padv_i,
   input  wire                              pipeline_flush_i,
   input  wire dx_pkg::operand_t              decode_pc_i,
   input  wire dx_pkg::op_class_e             decode_op_i,
   input  wire                              decode_rf_wb_i,
   input  wire dx_pkg::rf_adr_t               decode_rfa_adr_i,
   input  wire dx_pkg::rf_adr_t               decode_rfb_adr_i,
   input  wire dx_pkg::rf_adr_t               decode_rfd_adr_i,
   input  wire [`DX_IMM16_WIDTH-1:0]        decode_imm16_i,
   input  wire [`DX_IMMJBR_UPPER_WIDTH-1:0] decode_immjbr_upper_i,
   input  wire dx_pkg::operand_t              decode_immediate_i,
   input  wire                              decode_immediate_sel_i,
   input  wire dx_pkg::operand_t              decode_rfb_i,
   input  wire dx_pkg::operand_t              execute_rfb_i,
   input  wire                              predicted_flag_i,
   input  wire                              ctrl_late_result_i,
   input  wire dx_pkg::rf_adr_t               ctrl_rfd_adr_i,
   output logic                             decode_branch_o,
   output dx_pkg::operand_t                   decode_branch_target_o,
   output logic                             decode_bubble_o,
   output dx_pkg::op_class_e                  execute_op_o,
   output logic                             execute_rf_wb_o,
   output dx_pkg::rf_adr_t                    execute_rfd_adr_o,
   output dx_pkg::operand_t                   execute_immediate_o,
   output logic                             execute_immediate_sel_o,
   output dx_pkg::operand_t                   pc_execute_o,
   output dx_pkg::operand_t                   execute_jal_result_o,
   output logic                             execute_predicted_flag_o,
   output dx_pkg::operand_t                   execute_mispredict_target_o,
   output logic                             execute_except_ibus_align_o,
   output logic                             execute_bubble_o,
   output logic                             decode_valid_o
);

   import dx_pkg::*;

   logic     jr_ready;
   operand_t next_pc;
   operand_t mispredict_target;
   logic     ibus_align;

   // execute-stage state feeds back into both decode-side blocks
   dx_hazard u_hazard (
      .padv_i             (padv_i),
      .decode_op_i        (decode_op_i),
      .decode_rfa_adr_i   (decode_rfa_adr_i),
      .decode_rfb_adr_i   (decode_rfb_adr_i),
      .execute_op_i       (execute_op_o),
      .execute_rf_wb_i    (execute_rf_wb_o),
      .execute_rfd_adr_i  (execute_rfd_adr_o),
      .ctrl_late_result_i (ctrl_late_result_i),
      .ctrl_rfd_adr_i     (ctrl_rfd_adr_i),
      .decode_bubble_o    (decode_bubble_o),
      .jr_ready_o         (jr_ready)
   );

   dx_branch u_branch (
      .pipeline_flush_i       (pipeline_flush_i),
      .decode_pc_i            (decode_pc_i),
      .decode_op_i            (decode_op_i),
      .decode_imm16_i         (decode_imm16_i),
      .decode_immjbr_upper_i  (decode_immjbr_upper_i),
      .predicted_flag_i       (predicted_flag_i),
      .decode_rfb_i           (decode_rfb_i),
      .execute_rfb_i          (execute_rfb_i),
      .jr_ready_i             (jr_ready),
      .execute_bubble_i       (execute_bubble_o),
      .execute_op_i           (execute_op_o),
      .decode_branch_o        (decode_branch_o),
      .decode_branch_target_o (decode_branch_target_o),
      .next_pc_o              (next_pc),
      .mispredict_target_o    (mispredict_target),
      .ibus_align_o           (ibus_align)
   );

   dx_stage_reg u_stage_reg (
      .clk                         (clk),
      .rst                         (rst),
      .padv_i                      (padv_i),
      .pipeline_flush_i            (pipeline_flush_i),
      .decode_bubble_i             (decode_bubble_o),
      .decode_pc_i                 (decode_pc_i),
      .decode_op_i                 (decode_op_i),
      .decode_rf_wb_i              (decode_rf_wb_i),
      .decode_rfd_adr_i            (decode_rfd_adr_i),
      .decode_immediate_i          (decode_immediate_i),
      .decode_immediate_sel_i      (decode_immediate_sel_i),
      .predicted_flag_i            (predicted_flag_i),
      .next_pc_i                   (next_pc),
      .mispredict_target_i         (mispredict_target),
      .ibus_align_i                (ibus_align),
      .execute_op_o                (execute_op_o),
      .execute_rf_wb_o             (execute_rf_wb_o),
      .execute_rfd_adr_o           (execute_rfd_adr_o),
      .execute_immediate_o         (execute_immediate_o),
      .execute_immediate_sel_o     (execute_immediate_sel_o),
      .pc_execute_o                (pc_execute_o),
      .execute_jal_result_o        (execute_jal_result_o),
      .execute_predicted_flag_o    (execute_predicted_flag_o),
      .execute_mispredict_target_o (execute_mispredict_target_o),
      .execute_except_ibus_align_o (execute_except_ibus_align_o),
      .execute_bubble_o            (execute_bubble_o),
      .decode_valid_o              (decode_valid_o)
   );

endmodule

`default_nettype wire

//--- dx_defines.svh
// width and configuration macros for the decode/execute boundary, included by the package and RTL
`ifndef DX_DEFINES_SVH
`define DX_DEFINES_SVH

// pc and operand width
`define DX_OPERAND_WIDTH 32

// register file index width
`define DX_RF_ADDR_WIDTH 5

// branch immediate fields, imm16 plus the upper bits of the jump offset
`define DX_IMM16_WIDTH 16
`define DX_IMMJBR_UPPER_WIDTH 10

// pc held in execute out of reset
`define DX_RESET_PC 32'h100

// 1: delay slot present, link and fall-through are pc+8
// 0: no delay slot, pc+4
`define DX_DELAY_SLOT 1

`endif

//--- dx_hazard.sv
// decode-side hazard detection, raises the bubble and tells branch resolution when jr may go
`default_nettype none

module dx_hazard (
   input  wire                  padv_i,
   input  wire dx_pkg::op_class_e decode_op_i,
   input  wire dx_pkg::rf_adr_t   decode_rfa_adr_i,
   input  wire dx_pkg::rf_adr_t   decode_rfb_adr_i,
   input  wire dx_pkg::op_class_e execute_op_i,
   input  wire                  execute_rf_wb_i,
   input  wire dx_pkg::rf_adr_t   execute_rfd_adr_i,
   input  wire                  ctrl_late_result_i,
   input  wire dx_pkg::rf_adr_t   ctrl_rfd_adr_i,
   output logic                 decode_bubble_o,
   output logic                 jr_ready_o
);

   import dx_pkg::*;

   logic ctrl_interlock;
   logic execute_late;
   logic execute_match_ab;
   logic execute_match_b;
   logic jr_stall;

   // control stage holds a load or mfspr whose result decode wants
   assign ctrl_interlock = ctrl_late_result_i &
                           ((decode_rfa_adr_i == ctrl_rfd_adr_i) ||
                            (decode_rfb_adr_i == ctrl_rfd_adr_i));

   // execute destination against the decode sources
   assign execute_match_ab = (decode_rfa_adr_i == execute_rfd_adr_i) ||
                             (decode_rfb_adr_i == execute_rfd_adr_i);
   assign execute_match_b  = (decode_rfb_adr_i == execute_rfd_adr_i);

   // load and mfspr only produce their result in control, bypass can't help
   assign execute_late = ((execute_op_i == OP_LOAD) || (execute_op_i == OP_MFSPR)) &
                         execute_match_ab;

   // jr needs its target register now, any pending writer blocks it
   assign jr_ready_o = ~(ctrl_interlock | (execute_rf_wb_i & execute_match_b));

   assign jr_stall = (decode_op_i == OP_JR) & ~jr_ready_o;

   // rfe bubbles too, which keeps fetch stalled while it walks to control
   always_comb begin
      decode_bubble_o = 1'b0;
      if (padv_i) begin
         decode_bubble_o = execute_late | jr_stall | (decode_op_i == OP_RFE);
      end
   end

endmodule

`default_nettype wire

//--- dx_pkg.sv
// shared types of the decode/execute boundary, imported by the RTL and the testbench
`default_nettype none

`include "dx_defines.svh"

package dx_pkg;

   // one pc or operand word
   typedef logic [`DX_OPERAND_WIDTH-1:0] operand_t;

   // register file index
   typedef logic [`DX_RF_ADDR_WIDTH-1:0] rf_adr_t;

   // instruction class as seen by execute
   typedef enum logic [3:0] {
      OP_NOP     = 4'd0,
      OP_ALU     = 4'd1,
      OP_SETFLAG = 4'd2,
      OP_LOAD    = 4'd3,
      OP_STORE   = 4'd4,
      OP_MFSPR   = 4'd5,
      OP_MTSPR   = 4'd6,
      // l.j, immediate jump without link
      OP_JUMP    = 4'd7,
      OP_JAL     = 4'd8,
      // jump to register, target comes from rfb
      OP_JR      = 4'd9,
      OP_BF      = 4'd10,
      OP_BNF     = 4'd11,
      OP_RFE     = 4'd12
   } op_class_e;

endpackage

`default_nettype wire

//--- dx_stage_reg.sv
// execute stage register, loads decode on advance, clears on flush, turns bubbles into nops
`default_nettype none

`include "dx_defines.svh"

module dx_stage_reg (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  padv_i,
   input  wire                  pipeline_flush_i,
   input  wire                  decode_bubble_i,
   input  wire dx_pkg::operand_t  decode_pc_i,
   input  wire dx_pkg::op_class_e decode_op_i,
   input  wire                  decode_rf_wb_i,
   input  wire dx_pkg::rf_adr_t   decode_rfd_adr_i,
   input  wire dx_pkg::operand_t  decode_immediate_i,
   input  wire                  decode_immediate_sel_i,
   input  wire                  predicted_flag_i,
   input  wire dx_pkg::operand_t  next_pc_i,
   input  wire dx_pkg::operand_t  mispredict_target_i,
   input  wire                  ibus_align_i,
   output dx_pkg::op_class_e      execute_op_o,
   output logic                 execute_rf_wb_o,
   output dx_pkg::rf_adr_t        execute_rfd_adr_o,
   output dx_pkg::operand_t       execute_immediate_o,
   output logic                 execute_immediate_sel_o,
   output dx_pkg::operand_t       pc_execute_o,
   output dx_pkg::operand_t       execute_jal_result_o,
   output logic                 execute_predicted_flag_o,
   output dx_pkg::operand_t       execute_mispredict_target_o,
   output logic                 execute_except_ibus_align_o,
   output logic                 execute_bubble_o,
   output logic                 decode_valid_o
);

   import dx_pkg::*;

   logic rfe_held;
   logic cond_branch;

   // an rfe in execute waits there for the flush it causes
   assign rfe_held    = (execute_op_o == OP_RFE);
   assign cond_branch = (decode_op_i == OP_BF) || (decode_op_i == OP_BNF);

   always_ff @(posedge clk) begin
      if (rst || pipeline_flush_i) begin
         execute_op_o     <= OP_NOP;
         execute_rf_wb_o  <= 1'b0;
         execute_bubble_o <= 1'b0;
      end else if (padv_i) begin
         if (rfe_held) begin
            // whatever follows the rfe is squashed
            execute_op_o     <= OP_RFE;
            execute_rf_wb_o  <= 1'b0;
            execute_bubble_o <= 1'b1;
         end else if (decode_bubble_i) begin
            // rfe still goes through, everything else becomes a nop
            execute_op_o     <= (decode_op_i == OP_RFE) ? OP_RFE : OP_NOP;
            execute_rf_wb_o  <= 1'b0;
            execute_bubble_o <= 1'b1;
         end else begin
            execute_op_o     <= decode_op_i;
            execute_rf_wb_o  <= decode_rf_wb_i;
            execute_bubble_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc_execute_o                <= `DX_RESET_PC;
         execute_except_ibus_align_o <= 1'b0;
      end else if (padv_i) begin
         pc_execute_o                <= decode_pc_i;
         execute_except_ibus_align_o <= ibus_align_i;
      end
   end

   // padv one cycle late, flush does not matter here
   always_ff @(posedge clk) begin
      if (rst) begin
         decode_valid_o <= 1'b0;
      end else begin
         decode_valid_o <= padv_i;
      end
   end

   // operand payload
   always_ff @(posedge clk) begin
      if (padv_i) begin
         execute_rfd_adr_o       <= decode_rfd_adr_i;
         execute_immediate_o     <= decode_immediate_i;
         execute_immediate_sel_o <= decode_immediate_sel_i;
         execute_jal_result_o    <= next_pc_i;
      end
   end

   // prediction state only matters for conditional branches
   always_ff @(posedge clk) begin
      if (padv_i && cond_branch) begin
         execute_predicted_flag_o    <= predicted_flag_i;
         execute_mispredict_target_o <= mispredict_target_i;
      end
   end

endmodule

`default_nettype wire

//--- dx_testdata.txt
// decode/execute vectors, one per line, all fields hex
// id mask | padv flush pc op wb rfa rfb rfd imm16 upper imm sel drfb erfb pf late crfd
// | same cycle: branch target bubble | next cycle: op wb bub pc jal pf mtgt align
// mask: 1 branch/bubble, 2 target, 4 execute regs, 8 jal result, 10 prediction
// ops: 0 nop 1 alu 3 load 4 store 5 mfspr 7 j 8 jal 9 jr a bf b bnf c rfe

// reset values, an advance, then a flush
1 05  0 0 0    0 0 0 0 0  0    0   0  0 0    0    0 0 0  0 0    0  0 0 0 100  0    0 0    0
1 0d  1 0 200  1 1 1 2 3  0    0   11 1 0    0    0 0 0  0 0    0  1 1 0 200  208  0 0    0
1 0d  0 1 0    0 0 0 0 0  0    0   0  0 0    0    0 0 0  0 0    0  0 0 0 200  208  0 0    0

// load-use on rfa, no match, mfspr-use on rfb
2 0d  1 0 204  3 1 1 2 5  0    0   4  1 0    0    0 0 0  0 0    0  3 1 0 204  20c  0 0    0
2 0d  1 0 208  1 1 5 6 7  0    0   0  0 0    0    0 0 0  0 0    1  0 0 1 208  210  0 0    0
2 0d  1 0 20c  3 1 1 2 8  0    0   0  0 0    0    0 0 0  0 0    0  3 1 0 20c  214  0 0    0
2 0d  1 0 210  1 1 9 a b  0    0   0  0 0    0    0 0 0  0 0    0  1 1 0 210  218  0 0    0
2 0d  1 0 214  5 1 0 0 c  0    0   0  0 0    0    0 0 0  0 0    0  5 1 0 214  21c  0 0    0
2 0d  1 0 218  4 0 1 c 0  0    0   0  0 0    0    0 0 0  0 0    1  0 0 1 218  220  0 0    0

// j, jal backwards, bf and bnf under both predictions, flag holds on alu
3 0f  1 0 300  7 0 0 0 0  10   0   0  0 0    0    0 0 0  1 340  0  7 0 0 300  308  0 0    0
3 0f  1 0 400  8 1 0 0 9  fff0 3ff 0  0 0    0    0 0 0  1 3c0  0  8 1 0 400  408  0 0    0
3 1f  1 0 500  a 0 0 0 0  4    0   0  0 0    0    1 0 0  1 510  0  a 0 0 500  508  1 508  0
3 1d  1 0 600  a 0 0 0 0  8    0   0  0 0    0    0 0 0  0 0    0  a 0 0 600  608  0 620  0
3 1f  1 0 700  b 0 0 0 0  ffff 3ff 0  0 0    0    0 0 0  1 6fc  0  b 0 0 700  708  0 708  0
3 1d  1 0 800  b 0 0 0 0  2    0   0  0 0    0    1 0 0  0 0    0  b 0 0 800  808  1 808  0
3 1d  1 0 900  1 1 1 2 3  0    0   0  0 0    0    0 0 0  0 0    0  1 1 0 900  908  1 808  0

// jr with control interlock, after a bubble, from decode, execute writeback stall
4 1d  1 0 a00  9 0 0 4 0  0    0   0  0 1234 5678 0 1 4  0 0    1  0 0 1 a00  a08  1 808  0
4 1f  1 0 a04  9 0 0 4 0  0    0   0  0 1234 5678 0 0 0  1 5678 0  9 0 0 a04  a0c  1 808  0
4 1d  1 0 b00  1 1 1 2 6  0    0   0  0 0    0    0 0 0  0 0    0  1 1 0 b00  b08  1 808  0
4 1f  1 0 b04  9 0 0 7 0  0    0   0  0 1234 5678 0 0 0  1 1234 0  9 0 0 b04  b0c  1 808  0
4 1d  1 0 c00  1 1 1 2 8  0    0   0  0 0    0    0 0 0  0 0    0  1 1 0 c00  c08  1 808  0
4 1d  1 0 c04  9 0 0 8 0  0    0   0  0 1234 5678 0 0 0  0 0    1  0 0 1 c04  c0c  1 808  0
4 1f  1 0 c04  9 0 0 8 0  0    0   0  0 1234 5678 0 0 0  1 5678 0  9 0 0 c04  c0c  1 808  0

// rfe enters, squashes the next advance, holds, then a flush clears it
5 1d  1 0 d00  c 0 0 0 0  0    0   0  0 0    0    0 0 0  0 0    1  c 0 1 d00  d08  1 808  0
5 1d  1 0 d04  1 1 1 2 3  0    0   0  0 0    0    0 0 0  0 0    0  c 0 1 d04  d0c  1 808  0
5 1d  0 0 0    0 0 0 0 0  0    0   0  0 0    0    0 0 0  0 0    0  c 0 1 d04  d0c  1 808  0
5 1d  0 1 0    0 0 0 0 0  0    0   0  0 0    0    0 0 0  0 0    0  0 0 0 d04  d0c  1 808  0

// misaligned jr and bf targets, two held cycles, then an aligned advance
6 1f  1 0 e00  9 0 0 9 0  0    0   0  0 1001 5678 0 0 0  1 1001 0  9 0 0 e00  e08  1 808  1
6 1f  1 0 f02  a 0 0 0 0  1    0   0  0 0    0    1 0 0  1 f06  0  a 0 0 f02  f0a  1 f0a  1
6 1d  0 0 123  a 1 0 0 1f 10   0   ff 1 0    0    0 0 0  0 0    0  a 0 0 f02  f0a  1 f0a  1
6 1f  0 0 200  8 0 0 0 0  0    0   0  0 0    0    0 0 0  1 200  0  a 0 0 f02  f0a  1 f0a  1
6 1d  1 0 1000 1 1 1 1 2  0    0   0  0 0    0    0 0 0  0 0    0  1 1 0 1000 1008 1 f0a  0

//--- project.f
+incdir+.
dx_pkg.sv
dx_hazard.sv
dx_branch.sv
dx_stage_reg.sv
dx_decode_execute.sv
tb_clkgen.sv
tb_decode_execute.sv

//--- tb_clkgen.sv
// free running clock for the decode/execute testbench, instantiated once by the testbench top
`default_nettype none

module tb_clkgen (
   output logic clk_o
);

   // 40 time unit period
   localparam int HALF_PERIOD = 20;

   initial begin
      clk_o = 1'b0;
      forever begin
         #HALF_PERIOD clk_o = ~clk_o;
      end
   end

endmodule

`default_nettype wire

//--- tb_decode_execute.sv
// testbench top for the decode/execute boundary, runs the vectors of dx_testdata.txt against the DUT
`default_nettype none

`include "dx_defines.svh"

module tb_decode_execute;

   import dx_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 5;
   localparam int NUM_FIELDS   = 30;
   localparam int MAX_VECTORS  = 64;
   // decode outputs are sampled this long after the falling edge
   localparam int COMB_DELAY   = 5;

   // check mask bits, column 1 of a vector
   localparam int CHK_COMB   = 0;
   localparam int CHK_TARGET = 1;
   localparam int CHK_EXEC   = 2;
   localparam int CHK_JAL    = 3;
   localparam int CHK_PRED   = 4;

   logic                              clk;
   logic                              rst;
   logic                              padv;
   logic                              pipeline_flush;
   operand_t                          decode_pc;
   op_class_e                         decode_op;
   logic                              decode_rf_wb;
   rf_adr_t                           decode_rfa_adr;
   rf_adr_t                           decode_rfb_adr;
   rf_adr_t                           decode_rfd_adr;
   logic [`DX_IMM16_WIDTH-1:0]        decode_imm16;
   logic [`DX_IMMJBR_UPPER_WIDTH-1:0] decode_immjbr_upper;
   operand_t                          decode_immediate;
   logic                              decode_immediate_sel;
   operand_t                          decode_rfb;
   operand_t                          execute_rfb;
   logic                              predicted_flag;
   logic                              ctrl_late_result;
   rf_adr_t                           ctrl_rfd_adr;

   logic      decode_branch;
   operand_t  decode_branch_target;
   logic      decode_bubble;
   op_class_e execute_op;
   logic      execute_rf_wb;
   rf_adr_t   execute_rfd_adr;
   operand_t  execute_immediate;
   logic      execute_immediate_sel;
   operand_t  pc_execute;
   operand_t  execute_jal_result;
   logic      execute_predicted_flag;
   operand_t  execute_mispredict_target;
   logic      execute_except_ibus_align;
   logic      execute_bubble;
   logic      decode_valid;

   logic [31:0] vec_mem [0:NUM_FIELDS*MAX_VECTORS-1];
   int          num_vectors;
   bit          vectors_loaded;
   int          checks;
   int          errors;

   // operand payload expected in execute, follows the last advance
   bit       payload_valid;
   rf_adr_t  exp_rfd;
   operand_t exp_immediate;
   logic     exp_immediate_sel;

   tb_clkgen u_clkgen (
      .clk_o (clk)
   );

   dx_decode_execute dut (
      .clk                         (clk),
      .rst                         (rst),
      .padv_i                      (padv),
      .pipeline_flush_i            (pipeline_flush),
      .decode_pc_i                 (decode_pc),
      .decode_op_i                 (decode_op),
      .decode_rf_wb_i              (decode_rf_wb),
      .decode_rfa_adr_i            (decode_rfa_adr),
      .decode_rfb_adr_i            (decode_rfb_adr),
      .decode_rfd_adr_i            (decode_rfd_adr),
      .decode_imm16_i              (decode_imm16),
      .decode_immjbr_upper_i       (decode_immjbr_upper),
      .decode_immediate_i          (decode_immediate),
      .decode_immediate_sel_i      (decode_immediate_sel),
      .decode_rfb_i                (decode_rfb),
      .execute_rfb_i               (execute_rfb),
      .predicted_flag_i            (predicted_flag),
      .ctrl_late_result_i          (ctrl_late_result),
      .ctrl_rfd_adr_i              (ctrl_rfd_adr),
      .decode_branch_o             (decode_branch),
      .decode_branch_target_o      (decode_branch_target),
      .decode_bubble_o             (decode_bubble),
      .execute_op_o                (execute_op),
      .execute_rf_wb_o             (execute_rf_wb),
      .execute_rfd_adr_o           (execute_rfd_adr),
      .execute_immediate_o         (execute_immediate),
      .execute_immediate_sel_o     (execute_immediate_sel),
      .pc_execute_o                (pc_execute),
      .execute_jal_result_o        (execute_jal_result),
      .execute_predicted_flag_o    (execute_predicted_flag),
      .execute_mispredict_target_o (execute_mispredict_target),
      .execute_except_ibus_align_o (execute_except_ibus_align),
      .execute_bubble_o            (execute_bubble),
      .decode_valid_o              (decode_valid)
   );

   function automatic string behavior_name(input logic [31:0] id);
      case (id)
         1:       return "reset_flush";
         2:       return "load_use";
         3:       return "imm_branch";
         4:       return "reg_jump";
         5:       return "rfe_hold";
         6:       return "align_hold";
         default: return "unknown";
      endcase
   endfunction

   task automatic compare_value(input int v, input string what,
                                input logic [31:0] exp_val, input logic [31:0] act_val);
      checks++;
      assert (act_val === exp_val) else begin
         errors++;
         $display("ERR %s vector %0d %s expected %0h actual %0h",
                  behavior_name(vec_mem[v*NUM_FIELDS]), v, what, exp_val, act_val);
      end
   endtask

   task automatic idle_inputs();
      padv                 = 1'b0;
      pipeline_flush       = 1'b0;
      decode_pc            = '0;
      decode_op            = OP_NOP;
      decode_rf_wb         = 1'b0;
      decode_rfa_adr       = '0;
      decode_rfb_adr       = '0;
      decode_rfd_adr       = '0;
      decode_imm16         = '0;
      decode_immjbr_upper  = '0;
      decode_immediate     = '0;
      decode_immediate_sel = 1'b0;
      decode_rfb           = '0;
      execute_rfb          = '0;
      predicted_flag       = 1'b0;
      ctrl_late_result     = 1'b0;
      ctrl_rfd_adr         = '0;
   endtask

   // a vector counts while its behavior id is nonzero
   task automatic load_vectors();
      for (int i = 0; i < NUM_FIELDS*MAX_VECTORS; i++) begin
         vec_mem[i] = '0;
      end
      $readmemh("dx_testdata.txt", vec_mem);
      num_vectors = 0;
      while (num_vectors < MAX_VECTORS && vec_mem[num_vectors*NUM_FIELDS] != 0) begin
         num_vectors++;
      end
      if (num_vectors == 0) begin
         errors++;
         $display("no test vectors were read from dx_testdata.txt");
      end
      vectors_loaded = 1'b1;
   endtask

   // columns 2 to 18 are stimulus
   task automatic apply_vector(input int v);
      int base;
      base = v * NUM_FIELDS;
      padv                 = vec_mem[base+2][0];
      pipeline_flush       = vec_mem[base+3][0];
      decode_pc            = vec_mem[base+4];
      decode_op            = op_class_e'(vec_mem[base+5][3:0]);
      decode_rf_wb         = vec_mem[base+6][0];
      decode_rfa_adr       = vec_mem[base+7][`DX_RF_ADDR_WIDTH-1:0];
      decode_rfb_adr       = vec_mem[base+8][`DX_RF_ADDR_WIDTH-1:0];
      decode_rfd_adr       = vec_mem[base+9][`DX_RF_ADDR_WIDTH-1:0];
      decode_imm16         = vec_mem[base+10][`DX_IMM16_WIDTH-1:0];
      decode_immjbr_upper  = vec_mem[base+11][`DX_IMMJBR_UPPER_WIDTH-1:0];
      decode_immediate     = vec_mem[base+12];
      decode_immediate_sel = vec_mem[base+13][0];
      decode_rfb           = vec_mem[base+14];
      execute_rfb          = vec_mem[base+15];
      predicted_flag       = vec_mem[base+16][0];
      ctrl_late_result     = vec_mem[base+17][0];
      ctrl_rfd_adr         = vec_mem[base+18][`DX_RF_ADDR_WIDTH-1:0];
      // the payload loads on every advance
      if (padv) begin
         payload_valid     = 1'b1;
         exp_rfd           = decode_rfd_adr;
         exp_immediate     = decode_immediate;
         exp_immediate_sel = decode_immediate_sel;
      end
   endtask

   // columns 19 to 21, same cycle as the stimulus
   task automatic check_decode_outputs(input int v);
      int          base;
      logic [31:0] mask;
      base = v * NUM_FIELDS;
      mask = vec_mem[base+1];
      if (mask[CHK_COMB]) begin
         compare_value(v, "decode_branch_o", vec_mem[base+19], 32'(decode_branch));
         compare_value(v, "decode_bubble_o", vec_mem[base+21], 32'(decode_bubble));
      end
      if (mask[CHK_TARGET]) begin
         compare_value(v, "decode_branch_target_o", vec_mem[base+20],
                       32'(decode_branch_target));
      end
   endtask

   // columns 22 to 29, one rising edge after the stimulus
   task automatic verify_execute_stage(input int v);
      int          base;
      logic [31:0] mask;
      base = v * NUM_FIELDS;
      mask = vec_mem[base+1];
      compare_value(v, "decode_valid_o", vec_mem[base+2], 32'(decode_valid));
      if (mask[CHK_EXEC]) begin
         compare_value(v, "execute_op_o", vec_mem[base+22], 32'(execute_op));
         compare_value(v, "execute_rf_wb_o", vec_mem[base+23], 32'(execute_rf_wb));
         compare_value(v, "execute_bubble_o", vec_mem[base+24], 32'(execute_bubble));
         compare_value(v, "pc_execute_o", vec_mem[base+25], 32'(pc_execute));
         compare_value(v, "execute_except_ibus_align_o", vec_mem[base+29],
                       32'(execute_except_ibus_align));
         if (payload_valid) begin
            compare_value(v, "execute_rfd_adr_o", 32'(exp_rfd), 32'(execute_rfd_adr));
            compare_value(v, "execute_immediate_o", 32'(exp_immediate),
                          32'(execute_immediate));
            compare_value(v, "execute_immediate_sel_o", 32'(exp_immediate_sel),
                          32'(execute_immediate_sel));
         end
      end
      if (mask[CHK_JAL]) begin
         compare_value(v, "execute_jal_result_o", vec_mem[base+26], 32'(execute_jal_result));
      end
      if (mask[CHK_PRED]) begin
         compare_value(v, "execute_predicted_flag_o", vec_mem[base+27],
                       32'(execute_predicted_flag));
         compare_value(v, "execute_mispredict_target_o", vec_mem[base+28],
                       32'(execute_mispredict_target));
      end
   endtask

   initial begin : stimulus
      checks         = 0;
      errors         = 0;
      payload_valid  = 1'b0;
      vectors_loaded = 1'b0;
      rst            = 1'b1;
      idle_inputs();
      load_vectors();
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int v = 0; v < num_vectors; v++) begin
         apply_vector(v);
         #(COMB_DELAY);
         check_decode_outputs(v);
         @(negedge clk);
         verify_execute_stage(v);
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // four clock periods per vector, plus the reset
   initial begin : watchdog
      longint limit;
      wait (vectors_loaded);
      limit = longint'(num_vectors + RESET_CYCLES + 2) * CLK_PERIOD * 4;
      #(limit);
      $display("watchdog timeout, the vectors did not finish within %0d time units", limit);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire
